//--- design/conv_pkg.sv
package conv_pkg;

	localparam int addr_w = 32;
	localparam int dim_w = 5;
	localparam int taps = 9;
	localparam int pix_w = 8;
	localparam int widx_w = 2;
	localparam int wword_w = taps * widx_w;
	// 31 channels x 9 taps x 16-bit products fit with margin
	localparam int acc_w = 24;

	// output byte window, same for bias and sum
	localparam int scale_lsb = 5;
	localparam int scale_msb = 12;

	// word offsets in parameter memory
	localparam int param_rows = 0;
	localparam int param_channels = 1;
	localparam int param_kernels = 2;

	typedef enum logic [2:0] {
		idle,
		load_param,
		load_bias,
		load_weight,
		fetch,
		drain,
		write,
		done
	} conv_state_t;

	// window row of tap t, 0..2 top to bottom
	function automatic logic [1:0] tap_row(input logic [3:0] t);
		return 2'(t / 4'd3);
	endfunction

	// window column of tap t, 0..2 left to right
	function automatic logic [1:0] tap_col(input logic [3:0] t);
		return 2'(t % 4'd3);
	endfunction

endpackage

//--- design/conv_ctrl.sv
`timescale 1ns/1ns

module conv_ctrl (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           start,
	input  logic [conv_pkg::addr_w-1:0]    param_rdata,
	input  logic                           tap_pad,
	output conv_pkg::conv_state_t          state,
	output logic [conv_pkg::dim_w-1:0]     rows,
	output logic [conv_pkg::dim_w-1:0]     channels,
	output logic [conv_pkg::dim_w-1:0]     kernels,
	output logic [conv_pkg::dim_w-1:0]     row,
	output logic [conv_pkg::dim_w-1:0]     col,
	output logic [conv_pkg::dim_w-1:0]     chan,
	output logic [conv_pkg::dim_w-1:0]     kern,
	output logic [3:0]                     tap,
	output logic                           param_en,
	output logic                           bias_en,
	output logic                           weight_en,
	output logic                           input_en,
	output logic                           tap_valid,
	output logic                           acc_clear,
	output logic                           out_strobe,
	output logic                           finish
);
	import conv_pkg::*;

	logic last_col;
	logic last_row;
	logic last_chan;
	logic last_kern;

	assign last_col = (col == rows - 1'b1);
	assign last_row = (row == rows - 1'b1);
	assign last_chan = (chan == channels - 1'b1);
	assign last_kern = (kern == kernels - 1'b1);

	// tap doubles as the phase counter of the load states
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= idle;
			tap <= '0;
			row <= '0;
			col <= '0;
			chan <= '0;
			kern <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= load_param;
						tap <= '0;
						row <= '0;
						col <= '0;
						chan <= '0;
						kern <= '0;
					end
				end
				load_param: begin
					tap <= tap + 1'b1;
					if (tap == 4'd3) begin
						tap <= '0;
						state <= load_bias;
					end
				end
				load_bias: begin
					tap <= tap + 1'b1;
					if (tap == 4'd1) begin
						tap <= '0;
						state <= load_weight;
					end
				end
				load_weight: begin
					tap <= tap + 1'b1;
					if (tap == 4'd1) begin
						tap <= '0;
						state <= fetch;
					end
				end
				fetch: begin
					tap <= tap + 1'b1;
					if (tap == 4'(taps - 1)) begin
						tap <= '0;
						state <= drain;
					end
				end
				drain: begin
					if (last_chan) begin
						chan <= '0;
						state <= write;
					end else begin
						chan <= chan + 1'b1;
						state <= load_weight;
					end
				end
				write: begin
					state <= load_weight;
					if (last_col) begin
						col <= '0;
						if (last_row) begin
							row <= '0;
							if (last_kern) begin
								state <= done;
							end else begin
								kern <= kern + 1'b1;
								state <= load_bias;
							end
						end else begin
							row <= row + 1'b1;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// data for word n arrives at tap n+1
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rows <= '0;
			channels <= '0;
			kernels <= '0;
		end else if (state == load_param) begin
			case (tap)
				4'(param_rows + 1):     rows <= param_rdata[dim_w-1:0];
				4'(param_channels + 1): channels <= param_rdata[dim_w-1:0];
				4'(param_kernels + 1):  kernels <= param_rdata[dim_w-1:0];
				default: ;
			endcase
		end
	end

	// lines up with input_rdata
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			tap_valid <= 1'b0;
		else
			tap_valid <= (state == fetch) && !tap_pad;
	end

	assign param_en = (state == load_param) && (tap != 4'd3);
	assign bias_en = (state == load_bias) && (tap == 4'd0);
	assign weight_en = (state == load_weight) && (tap == 4'd0);
	assign input_en = (state == fetch) && !tap_pad;
	assign acc_clear = (state == load_weight) && (tap == 4'd0) && (chan == '0);
	assign out_strobe = (state == write);
	assign finish = (state == done);

	// loop counters stay inside the latched layer
	assert property (@(posedge clk) disable iff (rst)
		state == fetch |-> row < rows && col < rows && chan < channels && kern < kernels)
		else $error("loop counter outside layer");

endmodule

//--- design/conv_addr_gen.sv
`timescale 1ns/1ns

module conv_addr_gen (
	input  logic [conv_pkg::dim_w-1:0]  rows,
	input  logic [conv_pkg::dim_w-1:0]  channels,
	input  logic [conv_pkg::dim_w-1:0]  row,
	input  logic [conv_pkg::dim_w-1:0]  col,
	input  logic [conv_pkg::dim_w-1:0]  chan,
	input  logic [conv_pkg::dim_w-1:0]  kern,
	input  logic [3:0]                  tap,
	output logic [conv_pkg::addr_w-1:0] param_addr,
	output logic [conv_pkg::addr_w-1:0] bias_addr,
	output logic [conv_pkg::addr_w-1:0] weight_addr,
	output logic [conv_pkg::addr_w-1:0] input_addr,
	output logic [conv_pkg::addr_w-1:0] output_addr,
	output logic                        tap_pad
);
	import conv_pkg::*;

	logic [addr_w-1:0] n;
	logic [addr_w-1:0] n_sq;
	// window position plus one, so the top and left pad land on 0
	logic [dim_w:0]    r_ext;
	logic [dim_w:0]    c_ext;
	logic [addr_w-1:0] pix_row;
	logic [addr_w-1:0] pix_col;

	assign n = addr_w'(rows);
	assign n_sq = n * n;

	assign r_ext = {1'b0, row} + tap_row(tap);
	assign c_ext = {1'b0, col} + tap_col(tap);

	assign tap_pad = (r_ext == '0) || (r_ext > rows) || (c_ext == '0) || (c_ext > rows);

	assign pix_row = addr_w'(r_ext) - addr_w'(1);
	assign pix_col = addr_w'(c_ext) - addr_w'(1);

	// only meaningful while param_en is high
	assign param_addr = addr_w'(tap[1:0]);
	assign bias_addr = addr_w'(kern);
	assign weight_addr = addr_w'(kern) * addr_w'(channels) + addr_w'(chan);
	assign input_addr = addr_w'(chan) * n_sq + pix_row * n + pix_col;
	assign output_addr = addr_w'(kern) * n_sq + addr_w'(row) * n + addr_w'(col);

endmodule

//--- design/conv_weight_decode.sv
`timescale 1ns/1ns

module conv_weight_decode (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             start,
	input  logic [31:0]                                      w8,
	input  logic                                             weight_load,
	input  logic [conv_pkg::wword_w-1:0]                     weight_rdata,
	output logic [conv_pkg::taps-1:0][conv_pkg::pix_w-1:0]   tap_weight
);
	import conv_pkg::*;

	logic [3:0][pix_w-1:0] codebook;
	logic                  load_q;

	always_ff @(posedge clk) begin
		if (start)
			codebook <= w8;
	end

	// weight_rdata is valid one cycle after the read strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			load_q <= 1'b0;
		else
			load_q <= weight_load;
	end

	// index 0 picks the low byte of w8
	always_ff @(posedge clk) begin
		if (load_q) begin
			for (int i = 0; i < taps; i++)
				tap_weight[i] <= codebook[weight_rdata[i*widx_w +: widx_w]];
		end
	end

endmodule

//--- design/conv_mac.sv
`timescale 1ns/1ns

module conv_mac (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic [conv_pkg::pix_w-1:0]                     input_rdata,
	input  logic [conv_pkg::addr_w-1:0]                    bias_rdata,
	input  logic                                           bias_load,
	input  logic                                           tap_valid,
	input  logic [3:0]                                     tap,
	input  logic [conv_pkg::taps-1:0][conv_pkg::pix_w-1:0] tap_weight,
	input  logic                                           acc_clear,
	input  logic                                           out_strobe,
	output logic [7:0]                                     output_wdata,
	output logic                                           output_write
);
	import conv_pkg::*;

	logic                       bias_load_q;
	logic [addr_w-1:0]          bias_q;
	logic [3:0]                 tap_q;
	logic signed [2*pix_w-1:0]  product;
	logic signed [acc_w-1:0]    acc;
	logic signed [acc_w-1:0]    acc_d;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bias_load_q <= 1'b0;
			tap_q <= '0;
		end else begin
			bias_load_q <= bias_load;
			tap_q <= tap;
		end
	end

	always_ff @(posedge clk) begin
		if (bias_load_q)
			bias_q <= bias_rdata;
	end

	// tap_q selects the weight of the pixel now on input_rdata
	assign product = $signed(input_rdata) * $signed(tap_weight[tap_q]);

	always_comb begin
		acc_d = acc;
		if (acc_clear)
			acc_d = '0;
		else if (tap_valid)
			acc_d = acc + acc_w'(product);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else
			acc <= acc_d;
	end

	// follows acc_d so the byte is settled by the write cycle
	always_ff @(posedge clk) begin
		output_wdata <= bias_q[scale_msb:scale_lsb] + acc_d[scale_msb:scale_lsb];
	end

	assign output_write = out_strobe;

	assert property (@(posedge clk) disable iff (rst)
		tap_valid |-> tap_q < 4'(taps))
		else $error("tap index out of window");

endmodule

//--- design/conv_top.sv
`timescale 1ns/1ns

module conv_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic [31:0]                   w8,
	input  logic [conv_pkg::addr_w-1:0]   param_rdata,
	input  logic [conv_pkg::addr_w-1:0]   bias_rdata,
	input  logic [conv_pkg::wword_w-1:0]  weight_rdata,
	input  logic [conv_pkg::pix_w-1:0]    input_rdata,
	output logic                          param_en,
	output logic [conv_pkg::addr_w-1:0]   param_addr,
	output logic                          bias_en,
	output logic [conv_pkg::addr_w-1:0]   bias_addr,
	output logic                          weight_en,
	output logic [conv_pkg::addr_w-1:0]   weight_addr,
	output logic                          input_en,
	output logic [conv_pkg::addr_w-1:0]   input_addr,
	output logic                          output_write,
	output logic [conv_pkg::addr_w-1:0]   output_addr,
	output logic [7:0]                    output_wdata,
	output logic                          finish
);
	import conv_pkg::*;

	conv_state_t                state;
	logic [dim_w-1:0]           rows;
	logic [dim_w-1:0]           channels;
	logic [dim_w-1:0]           kernels;
	logic [dim_w-1:0]           row;
	logic [dim_w-1:0]           col;
	logic [dim_w-1:0]           chan;
	logic [dim_w-1:0]           kern;
	logic [3:0]                 tap;
	logic                       tap_pad;
	logic                       tap_valid;
	logic                       acc_clear;
	logic                       out_strobe;
	logic [taps-1:0][pix_w-1:0] tap_weight;

	conv_ctrl ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.param_rdata (param_rdata),
		.tap_pad     (tap_pad),
		.state       (state),
		.rows        (rows),
		.channels    (channels),
		.kernels     (kernels),
		.row         (row),
		.col         (col),
		.chan        (chan),
		.kern        (kern),
		.tap         (tap),
		.param_en    (param_en),
		.bias_en     (bias_en),
		.weight_en   (weight_en),
		.input_en    (input_en),
		.tap_valid   (tap_valid),
		.acc_clear   (acc_clear),
		.out_strobe  (out_strobe),
		.finish      (finish)
	);

	conv_addr_gen addr_gen_i (
		.rows        (rows),
		.channels    (channels),
		.row         (row),
		.col         (col),
		.chan        (chan),
		.kern        (kern),
		.tap         (tap),
		.param_addr  (param_addr),
		.bias_addr   (bias_addr),
		.weight_addr (weight_addr),
		.input_addr  (input_addr),
		.output_addr (output_addr),
		.tap_pad     (tap_pad)
	);

	// the read strobes double as load requests, delayed inside
	// codebook is taken only by a start the FSM accepts
	conv_weight_decode weight_decode_i (
		.clk          (clk),
		.rst          (rst),
		.start        (start && state == idle),
		.w8           (w8),
		.weight_load  (weight_en),
		.weight_rdata (weight_rdata),
		.tap_weight   (tap_weight)
	);

	conv_mac mac_i (
		.clk          (clk),
		.rst          (rst),
		.input_rdata  (input_rdata),
		.bias_rdata   (bias_rdata),
		.bias_load    (bias_en),
		.tap_valid    (tap_valid),
		.tap          (tap),
		.tap_weight   (tap_weight),
		.acc_clear    (acc_clear),
		.out_strobe   (out_strobe),
		.output_wdata (output_wdata),
		.output_write (output_write)
	);

	// writes stay inside the K*N*N output plane
	assert property (@(posedge clk) disable iff (rst)
		output_write |-> output_addr < addr_w'(kernels) * addr_w'(rows) * addr_w'(rows))
		else $error("output write out of range");

endmodule

//--- verification/conv_tb_mem.sv
`timescale 1ns/1ns

module conv_tb_mem (
	input  logic                          clk,
	input  logic                          clear,
	input  logic                          param_en,
	input  logic [conv_pkg::addr_w-1:0]   param_addr,
	output logic [conv_pkg::addr_w-1:0]   param_rdata,
	input  logic                          bias_en,
	input  logic [conv_pkg::addr_w-1:0]   bias_addr,
	output logic [conv_pkg::addr_w-1:0]   bias_rdata,
	input  logic                          weight_en,
	input  logic [conv_pkg::addr_w-1:0]   weight_addr,
	output logic [conv_pkg::wword_w-1:0]  weight_rdata,
	input  logic                          input_en,
	input  logic [conv_pkg::addr_w-1:0]   input_addr,
	output logic [conv_pkg::pix_w-1:0]    input_rdata,
	input  logic                          output_write,
	input  logic [conv_pkg::addr_w-1:0]   output_addr,
	input  logic [7:0]                    output_wdata
);
	import conv_pkg::*;

	localparam int depth = 256;

	logic [addr_w-1:0]  param_mem [0:3];
	logic [addr_w-1:0]  bias_mem [0:depth-1];
	logic [wword_w-1:0] weight_mem [0:depth-1];
	logic [pix_w-1:0]   input_mem [0:depth-1];
	logic [7:0]         out_mem [0:depth-1];
	int                 out_hits [0:depth-1];
	int                 stray_writes;

	initial begin
		param_rdata = '0;
		bias_rdata = '0;
		weight_rdata = '0;
		input_rdata = '0;
	end

	// data for a strobe shows up after the next edge
	always @(posedge clk) begin
		if (param_en)
			param_rdata <= param_mem[param_addr[1:0]];
		if (bias_en)
			bias_rdata <= bias_mem[bias_addr[7:0]];
		if (weight_en)
			weight_rdata <= weight_mem[weight_addr[7:0]];
		if (input_en)
			input_rdata <= input_mem[input_addr[7:0]];
	end

	// output capture, with a hit count per address
	always @(posedge clk) begin
		if (clear) begin
			for (int a = 0; a < depth; a++) begin
				out_mem[a] <= 8'h00;
				out_hits[a] <= 0;
			end
			stray_writes <= 0;
		end else if (output_write) begin
			if (output_addr < depth) begin
				out_mem[output_addr[7:0]] <= output_wdata;
				out_hits[output_addr[7:0]] <= out_hits[output_addr[7:0]] + 1;
			end else begin
				stray_writes <= stray_writes + 1;
			end
		end
	end

endmodule

//--- verification/conv_tb.sv
`timescale 1ns/1ns

module conv_tb;
	import conv_pkg::*;

	localparam int num_tests = 5;
	localparam int quiet_cycles = 5;
	localparam int busy_delay = 20;

	logic               clk = 1'b0;
	logic               rst;
	logic               start;
	logic [31:0]        w8;
	logic               clear;
	logic               param_en;
	logic [addr_w-1:0]  param_addr;
	logic [addr_w-1:0]  param_rdata;
	logic               bias_en;
	logic [addr_w-1:0]  bias_addr;
	logic [addr_w-1:0]  bias_rdata;
	logic               weight_en;
	logic [addr_w-1:0]  weight_addr;
	logic [wword_w-1:0] weight_rdata;
	logic               input_en;
	logic [addr_w-1:0]  input_addr;
	logic [pix_w-1:0]   input_rdata;
	logic               output_write;
	logic [addr_w-1:0]  output_addr;
	logic [7:0]         output_wdata;
	logic               finish;

	// one layer per entry
	int          tbl_rows [num_tests];
	int          tbl_channels [num_tests];
	int          tbl_kernels [num_tests];
	logic [31:0] tbl_codebook [num_tests];
	bit          tbl_busy_start [num_tests];

	integer seed = 32'hcdddc212;
	int     limit = 0;
	int     cycle_count = 0;
	int     finish_count = 0;
	int     quiet_errors = 0;
	logic   quiet = 1'b0;
	int     errors = 0;
	int     tests_failed = 0;

	conv_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.w8           (w8),
		.param_rdata  (param_rdata),
		.bias_rdata   (bias_rdata),
		.weight_rdata (weight_rdata),
		.input_rdata  (input_rdata),
		.param_en     (param_en),
		.param_addr   (param_addr),
		.bias_en      (bias_en),
		.bias_addr    (bias_addr),
		.weight_en    (weight_en),
		.weight_addr  (weight_addr),
		.input_en     (input_en),
		.input_addr   (input_addr),
		.output_write (output_write),
		.output_addr  (output_addr),
		.output_wdata (output_wdata),
		.finish       (finish)
	);

	conv_tb_mem mem_i (
		.clk          (clk),
		.clear        (clear),
		.param_en     (param_en),
		.param_addr   (param_addr),
		.param_rdata  (param_rdata),
		.bias_en      (bias_en),
		.bias_addr    (bias_addr),
		.bias_rdata   (bias_rdata),
		.weight_en    (weight_en),
		.weight_addr  (weight_addr),
		.weight_rdata (weight_rdata),
		.input_en     (input_en),
		.input_addr   (input_addr),
		.input_rdata  (input_rdata),
		.output_write (output_write),
		.output_addr  (output_addr),
		.output_wdata (output_wdata)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= limit) begin
			$display("timeout: engine still busy after %0d cycles", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	// finish pulses, and any bus activity once a layer is done
	always @(posedge clk) begin
		if (finish)
			finish_count <= finish_count + 1;
		if (quiet && (param_en || bias_en || weight_en || input_en || output_write)) begin
			$display("memory access after finish at cycle %0d", cycle_count);
			quiet_errors <= quiet_errors + 1;
		end
	end

	function automatic int run_cycles(input int n, input int c, input int k);
		return 5 + k * (2 + n * n * (12 * c + 1));
	endfunction

	task load_table();
		tbl_rows = '{3, 4, 5, 4, 3};
		tbl_channels = '{1, 2, 2, 3, 2};
		tbl_kernels = '{1, 1, 2, 2, 2};
		// last two codebooks carry negative entries
		tbl_codebook = '{32'h08040201, 32'h0c060305, 32'h09050702,
			32'h80ff7fc3, 32'hf011e53a};
		tbl_busy_start = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
	endtask

	// zero padding, sum over channels, then bias and sum windows added mod 256
	function automatic logic [7:0] expected_byte(input int t, input int k, input int r,
		input int c);
		int                  n;
		int                  nc;
		int                  ch;
		int                  tp;
		int                  rr;
		int                  cc;
		int                  idx;
		logic [wword_w-1:0]  word;
		logic signed [7:0]   px;
		logic signed [7:0]   w;
		logic signed [31:0]  sum;
		logic [31:0]         bias;
		n = tbl_rows[t];
		nc = tbl_channels[t];
		sum = 0;
		for (ch = 0; ch < nc; ch++) begin
			word = mem_i.weight_mem[k * nc + ch];
			for (tp = 0; tp < 9; tp++) begin
				rr = r + tp / 3 - 1;
				cc = c + tp % 3 - 1;
				if (rr >= 0 && rr < n && cc >= 0 && cc < n) begin
					idx = word[2 * tp +: 2];
					w = tbl_codebook[t][8 * idx +: 8];
					px = mem_i.input_mem[ch * n * n + rr * n + cc];
					sum = sum + px * w;
				end
			end
		end
		bias = mem_i.bias_mem[k];
		return bias[scale_msb:scale_lsb] + sum[scale_msb:scale_lsb];
	endfunction

	task fill_memories(input int t);
		for (int a = 0; a < 256; a++) begin
			mem_i.bias_mem[a] = $random(seed);
			mem_i.weight_mem[a] = wword_w'($random(seed));
			mem_i.input_mem[a] = pix_w'($random(seed));
		end
		// codes 0..3 in turn across the taps
		mem_i.weight_mem[0] = 18'h0e4e4;
		mem_i.param_mem[param_rows] = tbl_rows[t];
		mem_i.param_mem[param_channels] = tbl_channels[t];
		mem_i.param_mem[param_kernels] = tbl_kernels[t];
		mem_i.param_mem[3] = 32'h0;
	endtask

	task run_layer(input int t);
		int         n;
		int         c;
		int         k;
		int         cycles;
		int         fin_before;
		int         quiet_before;
		int         test_errors;
		int         exp_hits;
		int         a;
		logic [7:0] exp_val;
		n = tbl_rows[t];
		c = tbl_channels[t];
		k = tbl_kernels[t];
		test_errors = 0;
		fill_memories(t);
		@(posedge clk);
		clear <= 1'b1;
		w8 <= tbl_codebook[t];
		@(posedge clk);
		clear <= 1'b0;
		fin_before = finish_count;
		quiet_before = quiet_errors;
		quiet = 1'b0;
		start <= 1'b1;
		if (tbl_busy_start[t]) begin
			fork
				begin
					repeat (busy_delay) @(posedge clk);
					start <= 1'b1;
					// a codebook that a busy engine must not take
					w8 <= ~w8;
					@(posedge clk);
					start <= 1'b0;
				end
			join_none
		end
		@(posedge clk);
		start <= 1'b0;
		cycles = 1;
		@(negedge clk);
		while (!finish) begin
			@(negedge clk);
			cycles++;
		end
		quiet = 1'b1;
		repeat (quiet_cycles) @(posedge clk);

		if (cycles != run_cycles(n, c, k)) begin
			$display("FAILED run length: got %h, expected %h", cycles, run_cycles(n, c, k));
			test_errors++;
		end
		if (finish_count - fin_before != 1) begin
			$display("FAILED finish pulses: got %h, expected %h",
				finish_count - fin_before, 1);
			test_errors++;
		end
		test_errors += quiet_errors - quiet_before;
		if (mem_i.stray_writes != 0) begin
			$display("FAILED stray_writes: got %h, expected %h", mem_i.stray_writes, 0);
			test_errors++;
		end
		for (a = 0; a < 256; a++) begin
			exp_hits = (a < k * n * n) ? 1 : 0;
			if (mem_i.out_hits[a] != exp_hits) begin
				$display("FAILED out_hits[%h]: got %h, expected %h", a,
					mem_i.out_hits[a], exp_hits);
				test_errors++;
			end
		end
		for (int kk = 0; kk < k; kk++) begin
			for (int r = 0; r < n; r++) begin
				for (int cc = 0; cc < n; cc++) begin
					a = kk * n * n + r * n + cc;
					exp_val = expected_byte(t, kk, r, cc);
					if (mem_i.out_mem[a] !== exp_val) begin
						$display("FAILED output_wdata at %h: got %h, expected %h", a,
							mem_i.out_mem[a], exp_val);
						test_errors++;
					end
				end
			end
		end

		errors += test_errors;
		if (test_errors == 0) begin
			$display("test %0d: %0dx%0d, %0d channels, %0d kernels, passed",
				t, n, n, c, k);
		end else begin
			$display("test %0d: %0dx%0d, %0d channels, %0d kernels, %0d errors",
				t, n, n, c, k, test_errors);
			tests_failed++;
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		w8 = 32'h0;
		clear = 1'b0;
		load_table();
		for (int t = 0; t < num_tests; t++)
			limit += run_cycles(tbl_rows[t], tbl_channels[t], tbl_kernels[t]) + 50;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		for (int t = 0; t < num_tests; t++)
			run_layer(t);
		$display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- conv.f
design/conv_pkg.sv
design/conv_ctrl.sv
design/conv_addr_gen.sv
design/conv_weight_decode.sv
design/conv_mac.sv
design/conv_top.sv
verification/conv_tb_mem.sv
verification/conv_tb.sv
